/* logic/video_consts.svh */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Horizontal raster timing, in pixel clocks.
`define H_ACTIVE      256
`define H_SYNC_START  272
`define H_SYNC_WIDTH  24
`define H_TOTAL       320

// Vertical raster timing, in lines.
`define V_ACTIVE      240
`define V_SYNC_START  244
`define V_SYNC_WIDTH  3
`define V_TOTAL       262

// Tile map geometry and sprite count.
`define TILE_COLS     32
`define TILE_ROWS     30
`define NUM_SPRITES   8

// Bus byte addresses, one 32-bit word per entry.
`define TILE_BASE     16'h0000
`define SPRITE_BASE   16'h1000

// Clocks from raster position to rgb.
`define PIPE_DELAY    3

`endif

/* logic/video_pkg.sv */
`default_nettype none

package video_pkg;

  typedef logic [8:0] hpos_t;
  typedef logic [8:0] vpos_t;

  // Zero is transparent for sprites and black on screen.
  typedef logic [3:0] color_t;

endpackage

`default_nettype wire

/* logic/gfx_pkg.sv */
`default_nettype none

package gfx_pkg;

  // One tile map cell.
  typedef struct packed {
    logic [3:0] glyph;
    logic [3:0] color;
  } tile_entry_t;

  // One sprite table slot, top bit first.
  typedef struct packed {
    logic       en;
    logic [3:0] color;
    logic [7:0] y;
    logic [8:0] x;
  } sprite_attr_t;

endpackage

`default_nettype wire

/* logic/sync_timing.sv */
`default_nettype none

`include "video_consts.svh"

module sync_timing (
  input  logic              clk,
  input  logic              rst_n,
  output video_pkg::hpos_t  hpos,
  output video_pkg::vpos_t  vpos,
  output logic              display_on,
  output logic              hsync_raw,
  output logic              vsync_raw
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hpos <= '0;
      vpos <= '0;
    end else if (hpos == `H_TOTAL - 1) begin
      hpos <= '0;
      vpos <= (vpos == `V_TOTAL - 1) ? '0 : vpos + 1'b1;
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  assign hsync_raw  = (hpos >= `H_SYNC_START) && (hpos < `H_SYNC_START + `H_SYNC_WIDTH);
  assign vsync_raw  = (vpos >= `V_SYNC_START) && (vpos < `V_SYNC_START + `V_SYNC_WIDTH);
  assign display_on = (hpos < `H_ACTIVE) && (vpos < `V_ACTIVE);

endmodule

`default_nettype wire

/* logic/vram_dp.sv */
`default_nettype none

module vram_dp #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 1024
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] bus_addr,
  input  logic                     bus_we,
  input  payload_t                 bus_wdata,
  output payload_t                 bus_rdata,
  input  logic [$clog2(DEPTH)-1:0] vid_addr,
  output payload_t                 vid_rdata
);

  payload_t mem [DEPTH] = '{default: '0};

  // Bus side. Read returns the old word on a write cycle.
  always_ff @(posedge clk) begin
    if (bus_we) begin
      mem[bus_addr] <= bus_wdata;
    end
    bus_rdata <= mem[bus_addr];
  end

  always_ff @(posedge clk) begin
    vid_rdata <= mem[vid_addr];
  end

endmodule

`default_nettype wire

/* logic/axil_vram_port.sv */
`default_nettype none

`include "video_consts.svh"

module axil_vram_port (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [15:0]                         awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [31:0]                         wdata,
  input  logic [3:0]                          wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  input  logic [15:0]                         araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [31:0]                         rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready,
  output logic [9:0]                          tile_addr,
  output logic                                tile_we,
  output gfx_pkg::tile_entry_t                tile_wdata,
  input  gfx_pkg::tile_entry_t                tile_rdata,
  output logic [$clog2(`NUM_SPRITES)-1:0]     spr_addr,
  output logic                                spr_we,
  output gfx_pkg::sprite_attr_t               spr_wdata,
  input  gfx_pkg::sprite_attr_t               spr_rdata
);

  localparam logic [1:0]  RESP_OKAY   = 2'b00;
  localparam logic [1:0]  RESP_SLVERR = 2'b10;
  localparam logic [15:0] TILE_BYTES  = 16'(`TILE_COLS * `TILE_ROWS * 4);
  localparam logic [15:0] SPR_BYTES   = 16'(`NUM_SPRITES * 4);
  localparam int          SPR_AW      = $clog2(`NUM_SPRITES);

  logic [15:0] sel_addr;
  logic [15:0] tile_off;
  logic [15:0] spr_off;
  logic        tile_hit;
  logic        spr_hit;
  logic        wr_accept;
  logic        rd_accept;
  logic        rd_pend;
  logic        rd_tile;
  logic        rd_spr;

  // ******************************
  // Address decode
  // ******************************

  // Write and read handshakes never share a cycle, so one decoder serves both.
  assign sel_addr = awready ? awaddr : araddr;
  assign tile_off = sel_addr - `TILE_BASE;
  assign spr_off  = sel_addr - `SPRITE_BASE;
  assign tile_hit = tile_off < TILE_BYTES;
  assign spr_hit  = spr_off < SPR_BYTES;

  assign tile_addr  = tile_off[11:2];
  assign spr_addr   = spr_off[SPR_AW+1:2];
  assign tile_we    = awready && tile_hit;
  assign spr_we     = awready && spr_hit;
  assign tile_wdata = gfx_pkg::tile_entry_t'(wdata[$bits(gfx_pkg::tile_entry_t)-1:0]);
  assign spr_wdata  = gfx_pkg::sprite_attr_t'(wdata[$bits(gfx_pkg::sprite_attr_t)-1:0]);

  // Entries are word-wide, so byte lanes carry no meaning here.
  assign wr_accept = awvalid && wvalid && !awready && !bvalid;
  assign rd_accept = arvalid && !arready && !rd_pend && !rvalid && !wr_accept;

  // ******************************
  // Handshake state
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= wr_accept;
      wready  <= wr_accept;
      arready <= rd_accept;
      rd_pend <= arready;
      if (awready) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awready) begin
      bresp <= (tile_hit || spr_hit) ? RESP_OKAY : RESP_SLVERR;
    end
    if (arready) begin
      rd_tile <= tile_hit;
      rd_spr  <= spr_hit;
    end
    // RAM data is valid one cycle after the address handshake.
    if (rd_pend) begin
      rresp <= (rd_tile || rd_spr) ? RESP_OKAY : RESP_SLVERR;
      if (rd_tile) begin
        rdata <= 32'(tile_rdata);
      end else if (rd_spr) begin
        rdata <= 32'(spr_rdata);
      end else begin
        rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/tile_renderer.sv */
`default_nettype none

`include "video_consts.svh"

module tile_renderer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  video_pkg::hpos_t     hpos,
  input  video_pkg::vpos_t     vpos,
  output logic [9:0]           map_addr,
  input  gfx_pkg::tile_entry_t map_data,
  output video_pkg::color_t    tile_color
);

  logic [2:0] row_q;
  logic [2:0] col_q;
  logic       lit;

  // Out-of-range positions wrap; they only occur in blanking.
  assign map_addr = 10'(vpos[8:3] * `TILE_COLS + hpos[8:3]);

  always_ff @(posedge clk) begin
    row_q <= vpos[2:0];
    col_q <= hpos[2:0];
  end

  always_comb begin
    case (map_data.glyph[1:0])
      2'd0: lit = 1'b0;
      2'd1: lit = 1'b1;
      2'd2: lit = row_q[0] ^ col_q[0];
      default: lit = (row_q == 3'd0) || (row_q == 3'd7) || (col_q == 3'd0) || (col_q == 3'd7);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tile_color <= '0;
    end else begin
      tile_color <= lit ? map_data.color : '0;
    end
  end

endmodule

`default_nettype wire

/* logic/sprite_renderer.sv */
`default_nettype none

`include "video_consts.svh"

module sprite_renderer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  video_pkg::hpos_t                  hpos,
  input  video_pkg::vpos_t                  vpos,
  output logic [$clog2(`NUM_SPRITES)-1:0]   table_addr,
  input  gfx_pkg::sprite_attr_t             table_data,
  output video_pkg::color_t                 sprite_color
);

  localparam int IDX_W = $clog2(`NUM_SPRITES);

  gfx_pkg::sprite_attr_t staging [`NUM_SPRITES];
  gfx_pkg::sprite_attr_t live    [`NUM_SPRITES];
  logic                  load_q;
  logic [IDX_W-1:0]      idx_q;
  video_pkg::hpos_t      h_q;
  video_pkg::vpos_t      v_q;
  video_pkg::color_t     pix_color;

  // Slot i is addressed at hpos H_ACTIVE+i and lands one cycle later.
  assign table_addr = IDX_W'(hpos - 9'(`H_ACTIVE));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_q <= 1'b0;
      idx_q  <= '0;
      staging <= '{default: '0};
      live    <= '{default: '0};
    end else begin
      load_q <= (hpos >= `H_ACTIVE) && (hpos < `H_ACTIVE + `NUM_SPRITES);
      idx_q  <= table_addr;
      if (load_q) begin
        staging[idx_q] <= table_data;
      end
      if (hpos == '0) begin
        live <= staging;
      end
    end
  end

  always_ff @(posedge clk) begin
    h_q <= hpos;
    v_q <= vpos;
  end

  // Walk from the top index down so the lowest covering sprite wins.
  always_comb begin : find_sprite
    logic [9:0] dx;
    logic [9:0] dy;
    pix_color = '0;
    for (int i = `NUM_SPRITES - 1; i >= 0; i--) begin
      dx = {1'b0, h_q} - {1'b0, live[i].x};
      dy = {1'b0, v_q} - {2'b0, live[i].y};
      if (live[i].en && (dx < 10'd8) && (dy < 10'd8)) begin
        pix_color = live[i].color;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sprite_color <= '0;
    end else begin
      sprite_color <= pix_color;
    end
  end

endmodule

`default_nettype wire

/* logic/pixel_mixer.sv */
`default_nettype none

`include "video_consts.svh"

module pixel_mixer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              display_on,
  input  logic              hsync_raw,
  input  logic              vsync_raw,
  input  video_pkg::color_t tile_color,
  input  video_pkg::color_t sprite_color,
  output logic              hsync,
  output logic              vsync,
  output video_pkg::color_t rgb
);

  logic [1:0]             de_d;
  logic [`PIPE_DELAY-1:0] hs_d;
  logic [`PIPE_DELAY-1:0] vs_d;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_d <= '0;
      hs_d <= '0;
      vs_d <= '0;
      rgb  <= '0;
    end else begin
      de_d <= {de_d[0], display_on};
      hs_d <= {hs_d[`PIPE_DELAY-2:0], hsync_raw};
      vs_d <= {vs_d[`PIPE_DELAY-2:0], vsync_raw};
      if (!de_d[1]) begin
        rgb <= '0;
      end else begin
        rgb <= (sprite_color != '0) ? sprite_color : tile_color;
      end
    end
  end

  assign hsync = hs_d[`PIPE_DELAY-1];
  assign vsync = vs_d[`PIPE_DELAY-1];

endmodule

`default_nettype wire

/* logic/video_top.sv */
`default_nettype none

`include "video_consts.svh"

module video_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [15:0]       awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [15:0]       araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  output logic              hsync,
  output logic              vsync,
  output video_pkg::color_t rgb
);

  localparam int SPR_AW = $clog2(`NUM_SPRITES);

  video_pkg::hpos_t      hpos;
  video_pkg::vpos_t      vpos;
  logic                  display_on;
  logic                  hsync_raw;
  logic                  vsync_raw;

  logic [9:0]            tile_addr;
  logic                  tile_we;
  gfx_pkg::tile_entry_t  tile_wdata;
  gfx_pkg::tile_entry_t  tile_rdata;
  logic [9:0]            map_addr;
  gfx_pkg::tile_entry_t  map_data;

  logic [SPR_AW-1:0]     spr_addr;
  logic                  spr_we;
  gfx_pkg::sprite_attr_t spr_wdata;
  gfx_pkg::sprite_attr_t spr_rdata;
  logic [SPR_AW-1:0]     table_addr;
  gfx_pkg::sprite_attr_t table_data;

  video_pkg::color_t     tile_color;
  video_pkg::color_t     sprite_color;

  // ******************************
  // Host side
  // ******************************

  axil_vram_port u_bus (
    .clk        (clk),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .tile_addr  (tile_addr),
    .tile_we    (tile_we),
    .tile_wdata (tile_wdata),
    .tile_rdata (tile_rdata),
    .spr_addr   (spr_addr),
    .spr_we     (spr_we),
    .spr_wdata  (spr_wdata),
    .spr_rdata  (spr_rdata)
  );

  vram_dp #(
    .payload_t (gfx_pkg::tile_entry_t),
    .DEPTH     (1024)
  ) u_tile_ram (
    .clk       (clk),
    .bus_addr  (tile_addr),
    .bus_we    (tile_we),
    .bus_wdata (tile_wdata),
    .bus_rdata (tile_rdata),
    .vid_addr  (map_addr),
    .vid_rdata (map_data)
  );

  vram_dp #(
    .payload_t (gfx_pkg::sprite_attr_t),
    .DEPTH     (`NUM_SPRITES)
  ) u_sprite_ram (
    .clk       (clk),
    .bus_addr  (spr_addr),
    .bus_we    (spr_we),
    .bus_wdata (spr_wdata),
    .bus_rdata (spr_rdata),
    .vid_addr  (table_addr),
    .vid_rdata (table_data)
  );

  // ******************************
  // Video side
  // ******************************

  sync_timing u_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .hpos       (hpos),
    .vpos       (vpos),
    .display_on (display_on),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw)
  );

  tile_renderer u_tiles (
    .clk        (clk),
    .rst_n      (rst_n),
    .hpos       (hpos),
    .vpos       (vpos),
    .map_addr   (map_addr),
    .map_data   (map_data),
    .tile_color (tile_color)
  );

  sprite_renderer u_sprites (
    .clk          (clk),
    .rst_n        (rst_n),
    .hpos         (hpos),
    .vpos         (vpos),
    .table_addr   (table_addr),
    .table_data   (table_data),
    .sprite_color (sprite_color)
  );

  pixel_mixer u_mixer (
    .clk          (clk),
    .rst_n        (rst_n),
    .display_on   (display_on),
    .hsync_raw    (hsync_raw),
    .vsync_raw    (vsync_raw),
    .tile_color   (tile_color),
    .sprite_color (sprite_color),
    .hsync        (hsync),
    .vsync        (vsync),
    .rgb          (rgb)
  );

endmodule

`default_nettype wire

/* testbench/tb_video_top.sv */
`default_nettype none

`include "video_consts.svh"

module tb_video_top;

  localparam int         CLK_PERIOD = 100;
  localparam int         TILE_COUNT = `TILE_COLS * `TILE_ROWS;
  localparam int         FRAME_TIME = `H_TOTAL * `V_TOTAL * CLK_PERIOD;
  localparam logic [1:0] OKAY       = 2'b00;
  localparam logic [1:0] SLVERR     = 2'b10;

  logic        clk;
  logic        rst_n;
  logic [15:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [15:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        hsync;
  logic        vsync;
  logic [3:0]  rgb;

  logic [7:0]  tile_shadow [TILE_COUNT] = '{default: '0};
  logic [21:0] spr_shadow  [`NUM_SPRITES] = '{default: '0};
  logic [31:0] rng_state = 32'd46;
  int          mh = 0;
  int          mv = 0;
  int          frame_cnt = 0;
  logic        vs_q = 1'b0;
  logic        check_en = 1'b0;
  logic [3:0]  exp_rgb;
  logic        exp_hsync;
  logic        exp_vsync;
  int          value_errs = 0;
  int          other_errs = 0;

  video_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(12 * FRAME_TIME);
    $display("timeout: the run did not finish within 12 frame periods");
    $display("TESTS FAILED");
    $finish;
  end

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [15:0] tile_addr_of(input int i);
    return 16'(`TILE_BASE + i * 4);
  endfunction

  function automatic logic [15:0] spr_addr_of(input int i);
    return 16'(`SPRITE_BASE + i * 4);
  endfunction

  task automatic log_mismatch(input string name, input logic [31:0] expv, input logic [31:0] actv);
    value_errs++;
    $display("error: time %0t, %s expected %0h, actual %0h", $time, name, expv, actv);
  endtask

  task automatic log_fault(input string what);
    other_errs++;
    $display("fault at time %0t: %s", $time, what);
  endtask

  // Sprites 0 to 3 sit within 8 pixels of each other, so they always overlap.
  function automatic logic [31:0] make_sprite(input int idx);
    logic [31:0] r;
    logic [8:0]  x;
    logic [7:0]  y;
    logic        en;
    r = xorshift32();
    if (idx < 4) begin
      x = 9'(100 + r[2:0]);
      y = 8'(60 + r[6:4]);
    end else begin
      x = 9'(r[8:0] % 270);
      y = 8'(r[16:9] % 250);
    end
    en = (idx != 5);
    return {r[31:22], en, r[21:18], y, x};
  endfunction

  function automatic logic [3:0] pixel_at(input int h, input int v);
    logic [7:0]  te;
    logic [21:0] sa;
    int          sx;
    int          sy;
    int          r;
    int          c;
    logic        lit;
    if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
      return 4'd0;
    end
    // The first covering sprite decides; a zero color lets the tile show.
    for (int i = 0; i < `NUM_SPRITES; i++) begin
      sa = spr_shadow[i];
      sx = int'(sa[8:0]);
      sy = int'(sa[16:9]);
      if (sa[21] && h >= sx && h < sx + 8 && v >= sy && v < sy + 8) begin
        if (sa[20:17] != 4'd0) begin
          return sa[20:17];
        end
        break;
      end
    end
    te = tile_shadow[(v / 8) * `TILE_COLS + h / 8];
    r = v % 8;
    c = h % 8;
    case (te[5:4])
      2'd0: lit = 1'b0;
      2'd1: lit = 1'b1;
      2'd2: lit = (r % 2) != (c % 2);
      default: lit = (r == 0) || (r == 7) || (c == 0) || (c == 7);
    endcase
    return lit ? te[3:0] : 4'd0;
  endfunction

  // ******************************
  // Frame model
  // ******************************

  // A rising vsync shows position (0, V_SYNC_START), so the next one is (1, V_SYNC_START).
  always @(posedge clk) begin
    vs_q <= vsync;
    if (vsync && !vs_q) begin
      mh        <= 1;
      mv        <= `V_SYNC_START;
      frame_cnt <= frame_cnt + 1;
    end else if (mh == `H_TOTAL - 1) begin
      mh <= 0;
      mv <= (mv == `V_TOTAL - 1) ? 0 : mv + 1;
    end else begin
      mh <= mh + 1;
    end
  end

  always_comb begin
    exp_rgb   = pixel_at(mh, mv);
    exp_hsync = (mh >= `H_SYNC_START) && (mh < `H_SYNC_START + `H_SYNC_WIDTH);
    exp_vsync = (mv >= `V_SYNC_START) && (mv < `V_SYNC_START + `V_SYNC_WIDTH);
  end

  // ******************************
  // Assertions
  // ******************************

  assert property (@(posedge clk) !rst_n |-> !hsync)
    else log_mismatch("hsync", 32'd0, 32'($sampled(hsync)));
  assert property (@(posedge clk) !rst_n |-> !vsync)
    else log_mismatch("vsync", 32'd0, 32'($sampled(vsync)));
  assert property (@(posedge clk) !rst_n |-> rgb == 4'd0)
    else log_mismatch("rgb", 32'd0, 32'($sampled(rgb)));

  assert property (@(posedge clk) disable iff (!check_en) rgb == exp_rgb)
    else log_mismatch("rgb", 32'($sampled(exp_rgb)), 32'($sampled(rgb)));
  assert property (@(posedge clk) disable iff (!check_en) hsync == exp_hsync)
    else log_mismatch("hsync", 32'($sampled(exp_hsync)), 32'($sampled(hsync)));
  assert property (@(posedge clk) disable iff (!check_en) vsync == exp_vsync)
    else log_mismatch("vsync", 32'($sampled(exp_vsync)), 32'($sampled(vsync)));

  assert property (@(posedge clk) disable iff (!rst_n) wready == awready)
    else log_fault("wready and awready did not pulse together");
  assert property (@(posedge clk) disable iff (!rst_n) awready |=> !awready)
    else log_fault("awready stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else log_fault("write response changed while bready was low");
  assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else log_fault("read response changed while rready was low");
  assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> !awready)
    else log_fault("write accepted while a write response was pending");
  assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> !arready)
    else log_fault("read accepted while a read response was pending");

  // ******************************
  // Bus driver
  // ******************************

  task automatic wait_awready();
    do @(posedge clk); while (!awready);
  endtask

  task automatic wait_arready();
    do @(posedge clk); while (!arready);
  endtask

  task automatic finish_write(input logic [1:0] exp_resp, input int span);
    while (!bvalid) @(posedge clk);
    assert (bresp == exp_resp) else log_mismatch("bresp", 32'(exp_resp), 32'(bresp));
    repeat (span) @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic finish_read(input logic [31:0] exp_data, input logic [1:0] exp_resp,
                             input int span);
    while (!rvalid) @(posedge clk);
    assert (rdata == exp_data) else log_mismatch("rdata", exp_data, rdata);
    assert (rresp == exp_resp) else log_mismatch("rresp", 32'(exp_resp), 32'(rresp));
    repeat (span) @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // The second request waits on the bus while the first response is held.
  task automatic write_two(input logic [15:0] a0, input logic [31:0] d0, input logic [1:0] r0,
                           input logic [15:0] a1, input logic [31:0] d1, input logic [1:0] r1,
                           input int span);
    @(posedge clk);
    awaddr  <= a0;
    wdata   <= d0;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    wait_awready();
    awaddr <= a1;
    wdata  <= d1;
    finish_write(r0, span);
    wait_awready();
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    finish_write(r1, span);
  endtask

  task automatic read_two(input logic [15:0] a0, input logic [31:0] e0, input logic [1:0] r0,
                          input logic [15:0] a1, input logic [31:0] e1, input logic [1:0] r1,
                          input int span);
    @(posedge clk);
    araddr  <= a0;
    arvalid <= 1'b1;
    wait_arready();
    araddr <= a1;
    finish_read(e0, r0, span);
    wait_arready();
    arvalid <= 1'b0;
    finish_read(e1, r1, span);
  endtask

  task automatic load_sprites(input int span_min, input int span_range);
    logic [31:0] d0;
    logic [31:0] d1;
    for (int i = 0; i < `NUM_SPRITES; i += 2) begin
      d0 = make_sprite(i);
      d1 = make_sprite(i + 1);
      write_two(spr_addr_of(i), d0, OKAY, spr_addr_of(i + 1), d1, OKAY,
                span_min + int'(xorshift32() % span_range));
      spr_shadow[i]     = d0[21:0];
      spr_shadow[i + 1] = d1[21:0];
    end
  endtask

  task automatic read_sprites(input int span_min, input int span_range);
    for (int i = 0; i < `NUM_SPRITES; i += 2) begin
      read_two(spr_addr_of(i), 32'(spr_shadow[i]), OKAY,
               spr_addr_of(i + 1), 32'(spr_shadow[i + 1]), OKAY,
               span_min + int'(xorshift32() % span_range));
    end
  endtask

  task automatic check_frame();
    int n;
    n = frame_cnt;
    wait (frame_cnt == n + 1);
    check_en = 1'b1;
    wait (frame_cnt == n + 2);
    check_en = 1'b0;
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    logic [31:0] d0;
    logic [31:0] d1;
    int          idx0;
    int          idx1;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hf;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Memories are still zero, so this frame is black and only the syncs move.
    check_frame();

    for (int i = 0; i < TILE_COUNT; i += 2) begin
      d0 = xorshift32();
      d1 = xorshift32();
      write_two(tile_addr_of(i), d0, OKAY, tile_addr_of(i + 1), d1, OKAY,
                int'(xorshift32() % 3));
      tile_shadow[i]     = d0[7:0];
      tile_shadow[i + 1] = d1[7:0];
    end
    check_frame();

    load_sprites(0, 2);
    check_frame();

    for (int k = 0; k < 8; k++) begin
      idx0 = int'(xorshift32() % TILE_COUNT);
      idx1 = int'(xorshift32() % TILE_COUNT);
      read_two(tile_addr_of(idx0), 32'(tile_shadow[idx0]), OKAY,
               tile_addr_of(idx1), 32'(tile_shadow[idx1]), OKAY, int'(xorshift32() % 4));
    end
    read_sprites(0, 4);
    // Both unmapped addresses alias entry 0 in the low address bits.
    write_two(16'h2000, xorshift32(), SLVERR, 16'h1020, xorshift32(), SLVERR, 1);
    read_two(16'h0f04, 32'd0, SLVERR, 16'h2000, 32'd0, SLVERR, 1);
    check_frame();

    // Long response stalls with the next request already waiting.
    load_sprites(3, 6);
    read_sprites(3, 6);
    check_frame();

    $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/video_pkg.sv
logic/gfx_pkg.sv
logic/sync_timing.sv
logic/vram_dp.sv
logic/axil_vram_port.sv
logic/tile_renderer.sv
logic/sprite_renderer.sv
logic/pixel_mixer.sv
logic/video_top.sv
testbench/tb_video_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_video_top -f compile.f -o sim_video

out="$(./obj_dir/sim_video)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
